// File: flist.f
rtl/cart_pkg.sv
rtl/snes_bus_if.sv
rtl/snes_bus_sync.sv
rtl/snes_dead_monitor.sv
rtl/rom_mapper.sv
rtl/mcu_rom_arbiter.sv
rtl/rom_port.sv
rtl/cart_top.sv
sim/tb_cart_top.sv

// File: sim/tb_cart_top.sv
`timescale 1ns/100ps

module tb_cart_top;

  import cart_pkg::*;

  localparam int rom_words   = 4096;   // 8 KB of ROM modelled
  localparam int n_writes    = 32;
  localparam int n_mcu_reads = 2 * n_writes + 8;
  localparam int cycle_limit = 2 * snes_dead_timeout + 20000;

  logic                   clk2 = 1'b0;
  logic                   reset;
  logic [snes_addr_w-1:0] snes_addr_in;
  logic                   snes_rd_in;
  logic                   snes_wr_in;
  logic                   snes_romsel_in;
  logic                   snes_cpu_clk_in = 1'b0;
  logic [data_w-1:0]      snes_data_in;
  logic [data_w-1:0]      snes_data_out;
  logic                   snes_data_oe;
  logic [15:0]            rom_data_in;
  logic [15:0]            rom_data_out;
  logic                   rom_data_oe;
  logic [rom_word_w-1:0]  rom_addr;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;
  mapper_t                mapper;
  logic [rom_addr_w-1:0]  rom_mask;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  logic [rom_addr_w-1:0]  mcu_addr;
  logic [data_w-1:0]      mcu_dout;
  logic [data_w-1:0]      mcu_din;
  logic                   mcu_rdy;
  logic                   snes_dead;

  logic [15:0]           rom_mem  [rom_words];
  logic [7:0]            shadow   [2 * rom_words];   // Expected ROM contents by byte
  logic [rom_addr_w-1:0] wr_addrs [n_writes];
  int                    exp_q [$];                  // Expected read byte, -1 for a write
  logic [31:0]           rng = 32'he4de_1782;
  logic                  cpu_clk_run = 1'b0;
  int                    cpu_div = 0;
  logic                  con_check_en = 1'b0;
  logic [7:0]            con_exp = '0;
  logic [rom_word_w-1:0] con_exp_addr = '0;
  int                    n_mcu_checks = 0;
  int                    n_con_checks = 0;
  int                    exp_byte;
  logic                  rdy_last = 1'b1;
  int                    cycles = 0;

  cart_top u_cart_top (
    .clk2            (clk2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_rd_in      (snes_rd_in),
    .snes_wr_in      (snes_wr_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data_in    (snes_data_in),
    .snes_data_out   (snes_data_out),
    .snes_data_oe    (snes_data_oe),
    .rom_data_in     (rom_data_in),
    .rom_data_out    (rom_data_out),
    .rom_data_oe     (rom_data_oe),
    .rom_addr        (rom_addr),
    .rom_we          (rom_we),
    .rom_bhe         (rom_bhe),
    .rom_ble         (rom_ble),
    .mapper          (mapper),
    .rom_mask        (rom_mask),
    .mcu_rrq         (mcu_rrq),
    .mcu_wrq         (mcu_wrq),
    .mcu_addr        (mcu_addr),
    .mcu_dout        (mcu_dout),
    .mcu_din         (mcu_din),
    .mcu_rdy         (mcu_rdy),
    .snes_dead       (snes_dead)
  );

  always #20 clk2 = ~clk2;

  ////////////////////////////////////////
  // ROM model and console clock
  ////////////////////////////////////////
  assign rom_data_in = rom_mem[rom_addr[11:0]];

  always @(posedge clk2) begin
    if (rom_we === 1'b0) begin
      if (rom_bhe === 1'b0) begin
        rom_mem[rom_addr[11:0]][15:8] <= rom_data_out[15:8];
      end
      if (rom_ble === 1'b0) begin
        rom_mem[rom_addr[11:0]][7:0] <= rom_data_out[7:0];
      end
    end
  end

  // CPU clock at 1/12 of clk2 while running
  always @(negedge clk2) begin
    if (!cpu_clk_run) begin
      snes_cpu_clk_in <= 1'b0;
      cpu_div         <= 0;
    end else if (cpu_div == 5) begin
      snes_cpu_clk_in <= ~snes_cpu_clk_in;
      cpu_div         <= 0;
    end else begin
      cpu_div <= cpu_div + 1;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected ROM byte address for a console address
  function automatic logic [rom_addr_w-1:0] ref_map(input mapper_t m,
                                                    input logic [23:0] a,
                                                    input logic [23:0] mask);
    logic [31:0] lin;
    if (m == map_lorom) begin
      lin = ((32'(a) >> 16) & 32'h7f) * 32'h8000 + (32'(a) & 32'h7fff);   // 32 KB per bank
    end else begin
      lin = 32'(a) & 32'h3f_ffff;
    end
    return lin[23:0] & mask;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // One MCU byte access, returns once mcu_rdy is back
  task automatic mcu_access(input logic is_write, input logic [23:0] addr,
                            input logic [7:0] data);
    mcu_addr = addr;
    mcu_dout = data;
    if (is_write) begin
      shadow[addr[12:0]] = data;
      exp_q.push_back(-1);
      mcu_wrq = 1'b1;
    end else begin
      exp_q.push_back(int'(shadow[addr[12:0]]));
      mcu_rrq = 1'b1;
    end
    @(negedge clk2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    check_value("mcu_rdy", mcu_rdy, 32'd0);
    while (mcu_rdy !== 1'b1) begin
      @(negedge clk2);
    end
  endtask

  task automatic console_read(input logic [23:0] addr);
    logic [rom_addr_w-1:0] mapped;
    mapped       = ref_map(mapper, addr, rom_mask);
    snes_addr_in = addr;
    con_exp      = shadow[mapped[12:0]];
    con_exp_addr = mapped[rom_addr_w-1:1];
    con_check_en = 1'b1;
    repeat (2) @(negedge clk2);
    snes_romsel_in = 1'b0;
    snes_rd_in     = 1'b0;
    while (snes_data_oe !== 1'b1) begin
      @(negedge clk2);
    end
    repeat (3) @(negedge clk2);   // Held a few cycles for the checker
    snes_rd_in     = 1'b1;
    snes_romsel_in = 1'b1;
    while (snes_data_oe !== 1'b0) begin
      @(negedge clk2);
    end
    con_check_en = 1'b0;
  endtask

  ////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////
  always @(negedge clk2) begin
    if (!reset) begin
      if (mcu_rdy === 1'b1 && rdy_last === 1'b0) begin
        if (exp_q.size() == 0) begin
          $display("mcu_rdy rose with no MCU request outstanding");
          abort_run();
        end else begin
          exp_byte = exp_q.pop_front();
          if (exp_byte >= 0) begin
            check_value("mcu_din", mcu_din, 32'(exp_byte));
            n_mcu_checks++;
          end
        end
      end
      rdy_last = mcu_rdy;
      check_value("rom_data_oe", rom_data_oe, 32'(rom_we === 1'b0));   // Only while writing
      if (con_check_en && snes_data_oe === 1'b1) begin
        check_value("rom_addr", rom_addr, 32'(con_exp_addr));
        check_value("snes_data_out", snes_data_out, con_exp);
        n_con_checks++;
      end
    end
  end

  always @(posedge clk2) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    reset          = 1'b1;
    snes_addr_in   = '0;
    snes_rd_in     = 1'b1;
    snes_wr_in     = 1'b1;
    snes_romsel_in = 1'b1;
    snes_data_in   = '0;
    mapper         = map_hirom;
    rom_mask       = 24'h00_1fff;
    mcu_rrq        = 1'b0;
    mcu_wrq        = 1'b0;
    mcu_addr       = '0;
    mcu_dout       = '0;
    for (int i = 0; i < rom_words; i++) begin
      rom_mem[i]        = 16'(i * 40503);   // Odd multiplier, every address bit counts
      shadow[2 * i]     = rom_mem[i][15:8]; // Even byte on the high lane
      shadow[2 * i + 1] = rom_mem[i][7:0];
    end
    repeat (4) @(negedge clk2);
    reset = 1'b0;
    @(negedge clk2);

    // Reset state
    check_value("mcu_rdy", mcu_rdy, 32'd1);
    check_value("rom_we", rom_we, 32'd1);
    check_value("snes_data_oe", snes_data_oe, 32'd0);
    check_value("snes_dead", snes_dead, 32'd1);

    // Console dead, MCU owns the ROM
    for (int i = 0; i < n_writes; i++) begin
      rng         = xorshift32(rng);
      wr_addrs[i] = rom_addr_w'(rng[12:0]);
      rng         = xorshift32(rng);
      mcu_access(1'b1, wr_addrs[i], rng[7:0]);
    end
    for (int i = 0; i < n_writes; i++) begin
      mcu_access(1'b0, wr_addrs[i], 8'h00);
      mcu_access(1'b0, wr_addrs[i] ^ 24'h1, 8'h00);   // Other lane of the word
    end

    // Console running, accesses wait for free slots
    cpu_clk_run = 1'b1;
    while (snes_dead !== 1'b0) begin
      @(negedge clk2);
    end
    for (int i = 0; i < 8; i++) begin
      mcu_access(1'b0, wr_addrs[4 * i], 8'h00);
    end

    // Console reads through both mappers
    mapper   = map_lorom;
    rom_mask = 24'hff_ffff;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      console_read({rng[20], rng[19:13], 1'b1, 2'b00, rng[12:0]});
    end
    mapper   = map_hirom;
    rom_mask = 24'h00_1fff;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      console_read({2'b11, rng[21:0]});
    end

    // Idle clock, then revival
    cpu_clk_run = 1'b0;
    repeat (snes_dead_timeout - 100) @(negedge clk2);
    check_value("snes_dead", snes_dead, 32'd0);
    while (snes_dead !== 1'b1) begin
      @(negedge clk2);
    end
    cpu_clk_run = 1'b1;
    while (snes_dead !== 1'b0) begin
      @(negedge clk2);
    end
    repeat (4) @(negedge clk2);

    if (exp_q.size() != 0 || n_mcu_checks != n_mcu_reads || n_con_checks == 0) begin
      $display("Not all accesses were checked: %0d MCU reads, %0d console samples, %0d open",
               n_mcu_checks, n_con_checks, exp_q.size());
      abort_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: rtl/cart_top.sv
`timescale 1ns/100ps

module cart_top (
  input  logic                             clk2,
  input  logic                             reset,
  // Console bus
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr_in,
  input  logic                             snes_rd_in,
  input  logic                             snes_wr_in,
  input  logic                             snes_romsel_in,
  input  logic                             snes_cpu_clk_in,
  input  logic [cart_pkg::data_w-1:0]      snes_data_in,
  output logic [cart_pkg::data_w-1:0]      snes_data_out,
  output logic                             snes_data_oe,
  // ROM
  input  logic [15:0]                      rom_data_in,
  output logic [15:0]                      rom_data_out,
  output logic                             rom_data_oe,
  output logic [cart_pkg::rom_word_w-1:0]  rom_addr,
  output logic                             rom_we,
  output logic                             rom_bhe,
  output logic                             rom_ble,
  // MCU channel
  input  cart_pkg::mapper_t                mapper,
  input  logic [cart_pkg::rom_addr_w-1:0]  rom_mask,
  input  logic                             mcu_rrq,
  input  logic                             mcu_wrq,
  input  logic [cart_pkg::rom_addr_w-1:0]  mcu_addr,
  input  logic [cart_pkg::data_w-1:0]      mcu_dout,
  output logic [cart_pkg::data_w-1:0]      mcu_din,
  output logic                             mcu_rdy,
  output logic                             snes_dead
);

  import cart_pkg::*;

  logic [rom_addr_w-1:0] mapped_addr;
  logic [rom_addr_w-1:0] mcu_addr_q;
  logic                  rom_hit;
  logic                  snes_revive;
  logic                  mcu_rd_hit;
  logic                  mcu_wr_hit;
  logic                  rom_byte_sel;

  snes_bus_if bus ();

  snes_bus_sync u_snes_bus_sync (
    .clk2            (clk2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_rd_in      (snes_rd_in),
    .snes_wr_in      (snes_wr_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus.src)
  );

  snes_dead_monitor u_snes_dead_monitor (
    .clk2        (clk2),
    .reset       (reset),
    .bus         (bus.sink),
    .snes_dead   (snes_dead),
    .snes_revive (snes_revive)
  );

  rom_mapper u_rom_mapper (
    .clk2        (clk2),
    .bus         (bus.sink),
    .mapper      (mapper),
    .rom_mask    (rom_mask),
    .mapped_addr (mapped_addr),
    .rom_hit     (rom_hit)
  );

  mcu_rom_arbiter u_mcu_rom_arbiter (
    .clk2         (clk2),
    .reset        (reset),
    .bus          (bus.sink),
    .rom_hit      (rom_hit),
    .snes_dead    (snes_dead),
    .snes_revive  (snes_revive),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .rom_rdata    (rom_data_in),
    .rom_byte_sel (rom_byte_sel),
    .mcu_addr_q   (mcu_addr_q),
    .mcu_rd_hit   (mcu_rd_hit),
    .mcu_wr_hit   (mcu_wr_hit),
    .mcu_din      (mcu_din),
    .mcu_rdy      (mcu_rdy)
  );

  rom_port u_rom_port (
    .bus           (bus.sink),
    .mapped_addr   (mapped_addr),
    .rom_hit       (rom_hit),
    .mcu_addr_q    (mcu_addr_q),
    .mcu_rd_hit    (mcu_rd_hit),
    .mcu_wr_hit    (mcu_wr_hit),
    .mcu_dout      (mcu_dout),
    .snes_data_in  (snes_data_in),
    .rom_data_in   (rom_data_in),
    .rom_addr      (rom_addr),
    .rom_byte_sel  (rom_byte_sel),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

// File: rtl/rom_port.sv
`timescale 1ns/100ps

module rom_port (
  snes_bus_if.sink                        bus,
  input  logic [cart_pkg::rom_addr_w-1:0] mapped_addr,
  input  logic                            rom_hit,
  input  logic [cart_pkg::rom_addr_w-1:0] mcu_addr_q,
  input  logic                            mcu_rd_hit,
  input  logic                            mcu_wr_hit,
  input  logic [cart_pkg::data_w-1:0]     mcu_dout,
  input  logic [cart_pkg::data_w-1:0]     snes_data_in,
  input  logic [15:0]                     rom_data_in,
  output logic [cart_pkg::rom_word_w-1:0] rom_addr,
  output logic                            rom_byte_sel,
  output logic [15:0]                     rom_data_out,
  output logic                            rom_data_oe,
  output logic                            rom_we,
  output logic                            rom_bhe,
  output logic                            rom_ble,
  output logic [cart_pkg::data_w-1:0]     snes_data_out,
  output logic                            snes_data_oe
);

  import cart_pkg::*;

  logic                  mcu_hit;
  logic [rom_addr_w-1:0] byte_addr;
  logic [data_w-1:0]     wr_byte;
  logic                  snes_rom_wr;

  assign mcu_hit = mcu_rd_hit | mcu_wr_hit;

  ////////////////////////////////////////
  // Address and byte lane
  ////////////////////////////////////////
  assign byte_addr    = mcu_hit ? mcu_addr_q : mapped_addr;
  assign rom_addr     = byte_addr[rom_addr_w-1:1];
  assign rom_byte_sel = byte_addr[0];

  // Odd byte on the low lane, enables active low
  assign rom_bhe = rom_byte_sel;
  assign rom_ble = ~rom_byte_sel;

  // Console write into the ROM area
  assign snes_rom_wr = rom_hit & ~bus.wr;

  // Write data, same byte on both lanes
  assign wr_byte      = mcu_wr_hit ? mcu_dout : snes_data_in;
  assign rom_data_out = {wr_byte, wr_byte};

  always_comb begin
    if (mcu_hit) begin
      rom_data_oe = mcu_wr_hit;
      rom_we      = ~mcu_wr_hit;
    end else begin
      rom_data_oe = snes_rom_wr;
      rom_we      = (rom_hit & bus.cpu_clk) ? bus.wr : 1'b1;   // Gated by CPU clock
    end
  end

  ////////////////////////////////////////
  // Console read data
  ////////////////////////////////////////
  assign snes_data_out = rom_byte_sel ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_oe  = rom_hit & ~bus.rd;

endmodule

// File: rtl/mcu_rom_arbiter.sv
`timescale 1ns/100ps

module mcu_rom_arbiter (
  input  logic                            clk2,
  input  logic                            reset,
  snes_bus_if.sink                        bus,
  input  logic                            rom_hit,
  input  logic                            snes_dead,
  input  logic                            snes_revive,
  input  logic                            mcu_rrq,
  input  logic                            mcu_wrq,
  input  logic [cart_pkg::rom_addr_w-1:0] mcu_addr,
  input  logic [15:0]                     rom_rdata,
  input  logic                            rom_byte_sel,
  output logic [cart_pkg::rom_addr_w-1:0] mcu_addr_q,
  output logic                            mcu_rd_hit,
  output logic                            mcu_wr_hit,
  output logic [cart_pkg::data_w-1:0]     mcu_din,
  output logic                            mcu_rdy
);

  import cart_pkg::*;

  arb_state_t         state_q;
  logic [delay_w-1:0] delay_q;
  logic               rd_pend_q;
  logic               wr_pend_q;
  logic               free_strobe_q;
  logic               free_slot;
  logic               access_end;

  ////////////////////////////////////////
  // Free slot detection
  ////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (reset) begin
      free_strobe_q <= 1'b0;
    end else begin
      free_strobe_q <= bus.cycle_start & ~rom_hit;   // Console cycle not on ROM
    end
  end

  assign free_slot  = bus.cycle_end | free_strobe_q;
  assign access_end = (state_q == st_mcu_rd_end) || (state_q == st_mcu_wr_end);

  assign mcu_rd_hit = (state_q == st_mcu_rd_addr);
  assign mcu_wr_hit = (state_q == st_mcu_wr_addr);

  // Request latch and ready
  always_ff @(posedge clk2) begin
    if (reset) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      mcu_rdy   <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend_q <= 1'b1;
      mcu_rdy   <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend_q <= 1'b1;
      mcu_rdy   <= 1'b0;
    end else if (access_end) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      mcu_rdy   <= 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (mcu_rrq | mcu_wrq) begin
      mcu_addr_q <= mcu_addr;
    end
  end

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (reset) begin
      state_q <= st_idle;
      delay_q <= '0;
    end else if (snes_revive) begin
      state_q <= st_idle;   // Restart, request stays pending
    end else begin
      case (state_q)
        st_idle: begin
          if (free_slot | snes_dead) begin
            if (rd_pend_q) begin
              state_q <= st_mcu_rd_addr;
              delay_q <= delay_w'(rom_cycle_len);
            end else if (wr_pend_q) begin
              state_q <= st_mcu_wr_addr;
              delay_q <= delay_w'(rom_cycle_len);
            end
          end
        end
        st_mcu_rd_addr, st_mcu_wr_addr: begin
          delay_q <= delay_q - 1'b1;
          if (delay_q == '0) begin
            state_q <= (state_q == st_mcu_rd_addr) ? st_mcu_rd_end : st_mcu_wr_end;
          end
        end
        default: state_q <= st_idle;   // Both end states
      endcase
    end
  end

  // Last capture wins, ROM has settled by then
  always_ff @(posedge clk2) begin
    if (mcu_rd_hit) begin
      mcu_din <= rom_byte_sel ? rom_rdata[7:0] : rom_rdata[15:8];
    end
  end

endmodule

// File: rtl/rom_mapper.sv
`timescale 1ns/100ps

module rom_mapper (
  input  logic                            clk2,
  snes_bus_if.sink                        bus,
  input  cart_pkg::mapper_t               mapper,
  input  logic [cart_pkg::rom_addr_w-1:0] rom_mask,
  output logic [cart_pkg::rom_addr_w-1:0] mapped_addr,
  output logic                            rom_hit
);

  import cart_pkg::*;

  logic [snes_addr_w-1:0] addr_q;
  logic [rom_addr_w-1:0]  hirom_addr;
  logic [rom_addr_w-1:0]  lorom_addr;
  logic [rom_addr_w-1:0]  raw_addr;

  // Early address tap, one register ahead of the ROM port
  always_ff @(posedge clk2) begin
    addr_q <= bus.addr_early;
  end

  ////////////////////////////////////////
  // Mapping rules
  ////////////////////////////////////////
  assign hirom_addr = rom_addr_w'(addr_q[21:0]);

  // 32k banks, A15 dropped
  assign lorom_addr = rom_addr_w'({addr_q[22:16], addr_q[14:0]});

  always_comb begin
    case (mapper)
      map_lorom: raw_addr = lorom_addr;
      map_hirom: raw_addr = hirom_addr;
      default:   raw_addr = hirom_addr;
    endcase
  end

  assign mapped_addr = raw_addr & rom_mask;

  // ROMSEL is active low
  assign rom_hit = ~bus.romsel;

endmodule

// File: rtl/snes_dead_monitor.sv
`timescale 1ns/100ps

module snes_dead_monitor (
  input  logic     clk2,
  input  logic     reset,
  snes_bus_if.sink bus,
  output logic     snes_dead,
  output logic     snes_revive
);

  import cart_pkg::*;

  logic [dead_cnt_w-1:0] idle_cnt_q;

  // Idle counter, saturates just past the timeout
  always_ff @(posedge clk2) begin
    if (reset) begin
      idle_cnt_q <= '0;
    end else if (bus.cpu_clk_raw) begin
      idle_cnt_q <= '0;
    end else if (idle_cnt_q <= dead_cnt_w'(snes_dead_timeout)) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (reset) begin
      snes_dead   <= 1'b1;   // Console assumed off until its clock runs
      snes_revive <= 1'b0;
    end else begin
      snes_revive <= 1'b0;
      if (bus.cpu_clk_raw) begin
        snes_dead   <= 1'b0;
        snes_revive <= snes_dead;   // First clock after a dead period
      end else if (idle_cnt_q > dead_cnt_w'(snes_dead_timeout)) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/snes_bus_sync.sv
`timescale 1ns/100ps

module snes_bus_sync (
  input  logic                             clk2,
  input  logic                             reset,
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr_in,
  input  logic                             snes_rd_in,
  input  logic                             snes_wr_in,
  input  logic                             snes_romsel_in,
  input  logic                             snes_cpu_clk_in,
  snes_bus_if.src                          bus
);

  import cart_pkg::*;

  localparam int addr_depth = sync_depth - 1;

  logic [sync_depth-1:0]  rd_sr;
  logic [sync_depth-1:0]  wr_sr;
  logic [sync_depth-1:0]  romsel_sr;
  logic [sync_depth-1:0]  cpu_clk_sr;
  logic [snes_addr_w-1:0] addr_sr [addr_depth];
  logic                   rd_end_q;
  logic                   wr_end_q;

  ////////////////////////////////////////
  // Input shift registers
  ////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (reset) begin
      rd_sr      <= '1;   // Bus strobes idle high
      wr_sr      <= '1;
      romsel_sr  <= '1;
      cpu_clk_sr <= '0;
    end else begin
      rd_sr      <= {rd_sr[sync_depth-2:0], snes_rd_in};
      wr_sr      <= {wr_sr[sync_depth-2:0], snes_wr_in};
      romsel_sr  <= {romsel_sr[sync_depth-2:0], snes_romsel_in};
      cpu_clk_sr <= {cpu_clk_sr[sync_depth-2:0], snes_cpu_clk_in};
    end
  end

  // Address pipeline
  always_ff @(posedge clk2) begin
    addr_sr[0] <= snes_addr_in;
    for (int i = 1; i < addr_depth; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  // End strobes one cycle later than the raw pattern
  always_ff @(posedge clk2) begin
    if (reset) begin
      rd_end_q <= 1'b0;
      wr_end_q <= 1'b0;
    end else begin
      rd_end_q <= ((rd_sr[5:0] & rd_sr[6:1]) == 6'b000001);
      wr_end_q <= ((wr_sr[5:0] & wr_sr[6:1]) == 6'b000001);
    end
  end

  ////////////////////////////////////////
  // Glitch filter, two adjacent taps
  ////////////////////////////////////////
  assign bus.rd          = rd_sr[2] & rd_sr[1];
  assign bus.wr          = wr_sr[2] & wr_sr[1];
  assign bus.cpu_clk     = cpu_clk_sr[2] & cpu_clk_sr[1];
  assign bus.romsel      = romsel_sr[5] & romsel_sr[4];   // Aligned with address
  assign bus.cpu_clk_raw = cpu_clk_sr[1];

  assign bus.addr       = addr_sr[6] & addr_sr[5];
  assign bus.addr_early = addr_sr[4] & addr_sr[3];

  // Edge patterns, older samples on the left
  assign bus.rd_start    = ((rd_sr[6:1] | rd_sr[7:2]) == 6'b111100);
  assign bus.rd_end      = rd_end_q;
  assign bus.wr_end      = wr_end_q;
  assign bus.cycle_start = ((cpu_clk_sr[7:2] & cpu_clk_sr[6:1]) == 6'b000011);
  assign bus.cycle_end   = ((cpu_clk_sr[7:2] | cpu_clk_sr[6:1]) == 6'b111000);

endmodule

// File: rtl/snes_bus_if.sv
`timescale 1ns/100ps

interface snes_bus_if;

  // Filtered address, late and early taps
  logic [cart_pkg::snes_addr_w-1:0] addr;
  logic [cart_pkg::snes_addr_w-1:0] addr_early;

  // Filtered levels, all active low except the clock
  logic rd;
  logic wr;
  logic romsel;
  logic cpu_clk;
  logic cpu_clk_raw;   // Second sample, unfiltered

  // Single-cycle strobes
  logic rd_start;
  logic rd_end;
  logic wr_end;
  logic cycle_start;
  logic cycle_end;

  modport src (
    output addr, addr_early, rd, wr, romsel, cpu_clk, cpu_clk_raw,
    output rd_start, rd_end, wr_end, cycle_start, cycle_end
  );

  modport sink (
    input addr, addr_early, rd, wr, romsel, cpu_clk, cpu_clk_raw,
    input rd_start, rd_end, wr_end, cycle_start, cycle_end
  );

endinterface

// File: rtl/cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  localparam int snes_addr_w = 24;
  localparam int rom_addr_w  = 24;               // Byte address into ROM
  localparam int rom_word_w  = rom_addr_w - 1;   // 16-bit word address
  localparam int data_w      = 8;

  // Control input sampling
  localparam int sync_depth = 8;

  ////////////////////////////////////////
  // Timing
  ////////////////////////////////////////
  localparam int rom_cycle_len = 7;              // Wait cycles per MCU access
  localparam int delay_w       = $clog2(rom_cycle_len + 1);

  // About 1 ms of idle CPU clock
  localparam int snes_dead_timeout = 96000;
  localparam int dead_cnt_w        = 18;

  // Address mapping rule
  typedef enum logic [1:0] {
    map_hirom = 2'd0,
    map_lorom = 2'd1
  } mapper_t;

  // MCU ROM access FSM
  typedef enum logic [2:0] {
    st_idle,
    st_mcu_rd_addr,
    st_mcu_rd_end,
    st_mcu_wr_addr,
    st_mcu_wr_end
  } arb_state_t;

endpackage
